//--- dram_pkg.sv
package dram_pkg;

    // L2 side
    localparam int l2_req_width = 20;   // raw instruction word
    localparam int data_width   = 8;    // one byte per request

    // DRAM geometry
    localparam int num_of_banks = 8;
    localparam int num_of_rows  = 128;
    localparam int num_of_cols  = 8;

    // instruction field widths, msb down: 4 unused, bank, row, col, offset
    localparam int bank_bits   = 3;
    localparam int row_bits    = 7;
    localparam int col_bits    = 3;
    localparam int offset_bits = 3;    // decoded but never used

    // command codes on the cmd bus
    localparam logic [1:0] cmd_act = 2'd0;  // load row into buffer
    localparam logic [1:0] cmd_wr  = 2'd1;
    localparam logic [1:0] cmd_rd  = 2'd2;
    localparam logic [1:0] cmd_pre = 2'd3;  // write buffer back to bank

    // request FIFO
    localparam int req_buf_depth = 8;

endpackage

//--- dram_req_if.sv
`timescale 1ns/1ps

interface dram_req_if;

    logic                             valid;
    logic                             rw;       // 1 = write
    logic [dram_pkg::bank_bits-1:0]   bank_id;
    logic [dram_pkg::row_bits-1:0]    row_id;
    logic [dram_pkg::col_bits-1:0]    col_id;
    logic [dram_pkg::data_width-1:0]  wdata;
    logic                             done;     // precharge finished

    // decode holds everything stable until done
    modport decode (
        output valid, rw, bank_id, row_id, col_id, wdata,
        input  done
    );

    modport execute (
        input  valid, rw, bank_id, row_id, col_id, wdata,
        output done
    );

endinterface

//--- l2_req_buffer.sv
`timescale 1ns/1ps

module l2_req_buffer (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              wr_en,
    input  logic                              wr_rw,
    input  logic [dram_pkg::l2_req_width-1:0] wr_instr,
    input  logic [dram_pkg::data_width-1:0]   wr_data,
    input  logic                              rd_en,
    output logic                              empty,
    output logic                              full,
    output logic                              head_rw,
    output logic [dram_pkg::l2_req_width-1:0] head_instr,
    output logic [dram_pkg::data_width-1:0]   head_data
);

    logic                              rw_mem    [dram_pkg::req_buf_depth];
    logic [dram_pkg::l2_req_width-1:0] instr_mem [dram_pkg::req_buf_depth];
    logic [dram_pkg::data_width-1:0]   data_mem  [dram_pkg::req_buf_depth];

    logic [$clog2(dram_pkg::req_buf_depth)-1:0] wr_ptr;
    logic [$clog2(dram_pkg::req_buf_depth)-1:0] rd_ptr;
    logic [$clog2(dram_pkg::req_buf_depth+1)-1:0] count;
    logic do_wr;
    logic do_rd;

    assign do_wr = wr_en && !full;   // strobe while full is lost
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            rw_mem[wr_ptr]    <= wr_rw;
            instr_mem[wr_ptr] <= wr_instr;
            data_mem[wr_ptr]  <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == dram_pkg::req_buf_depth - 1) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == dram_pkg::req_buf_depth - 1) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;   // both or neither, count holds
            endcase
        end
    end

    assign empty      = (count == 0);
    assign full       = (count == dram_pkg::req_buf_depth);
    assign head_rw    = rw_mem[rd_ptr];
    assign head_instr = instr_mem[rd_ptr];
    assign head_data  = data_mem[rd_ptr];

endmodule

//--- address_translate.sv
`timescale 1ns/1ps

module address_translate (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              empty,
    input  logic                              head_rw,
    input  logic [dram_pkg::l2_req_width-1:0] head_instr,
    input  logic [dram_pkg::data_width-1:0]   head_data,
    output logic                              rd_en,
    dram_req_if.decode                        req
);

    logic take;

    // valid doubles as the busy flag
    assign take = !req.valid && !empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            req.valid <= 1'b0;
            rd_en     <= 1'b0;
        end else begin
            rd_en <= take;               // pop in the cycle valid rises
            if (take)
                req.valid <= 1'b1;
            else if (req.done)
                req.valid <= 1'b0;       // gives a gap of one idle cycle at least
        end
    end

    // field slicing, offset bits at the bottom are skipped
    always_ff @(posedge clk) begin
        if (take) begin
            req.rw      <= head_rw;
            req.wdata   <= head_data;
            req.col_id  <= head_instr[dram_pkg::offset_bits +: dram_pkg::col_bits];
            req.row_id  <= head_instr[dram_pkg::offset_bits + dram_pkg::col_bits
                                      +: dram_pkg::row_bits];
            req.bank_id <= head_instr[dram_pkg::offset_bits + dram_pkg::col_bits
                                      + dram_pkg::row_bits +: dram_pkg::bank_bits];
        end
    end

endmodule

//--- dram_fsm.sv
`timescale 1ns/1ps

module dram_fsm (
    input  logic                                   clk,
    input  logic                                   reset,
    dram_req_if.execute                            req,
    input  logic                                   cmd_ack,
    input  logic                                   dram_rdata,
    output logic                                   cmd_req,
    output logic [1:0]                             cmd,
    output logic [dram_pkg::num_of_banks-1:0]      bank_sel,
    output logic [dram_pkg::num_of_rows-1:0]       row_sel,
    output logic [dram_pkg::num_of_cols-1:0]       col_sel,
    output logic                                   buf_en,
    output logic                                   buf_rw,
    output logic [$clog2(dram_pkg::data_width)-1:0] bit_idx,
    output logic                                   dram_wdata,
    output logic                                   rd_bit_strobe
);

    enum logic [2:0] {idle, act, access, beats, pre} state;

    logic ack_seen;   // ack came high, now waiting for it to drop
    logic [$clog2(dram_pkg::data_width)-1:0] access_count;
    logic last_beat;

    assign last_beat = (access_count == dram_pkg::data_width - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= idle;
            cmd_req      <= 1'b0;
            ack_seen     <= 1'b0;
            access_count <= '0;
            req.done     <= 1'b0;
        end else begin
            req.done <= 1'b0;
            case (state)
                idle: begin
                    // done still high means decode has not dropped valid yet
                    if (req.valid && !req.done) begin
                        state   <= act;
                        cmd_req <= 1'b1;
                    end
                end
                act, access, pre: begin
                    if (!ack_seen) begin
                        if (cmd_ack) begin
                            cmd_req  <= 1'b0;
                            ack_seen <= 1'b1;
                        end
                    end else if (!cmd_ack) begin   // four-phase cycle complete
                        ack_seen <= 1'b0;
                        if (state == act) begin
                            state   <= access;
                            cmd_req <= 1'b1;
                        end else if (state == access) begin
                            state        <= beats;
                            access_count <= '0;
                        end else begin
                            state    <= idle;
                            req.done <= 1'b1;
                        end
                    end
                end
                beats: begin
                    access_count <= access_count + 1'b1;
                    if (last_beat) begin
                        state   <= pre;
                        cmd_req <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // command follows the state, so it is settled when cmd_req rises
    always_comb begin
        case (state)
            access:  cmd = req.rw ? dram_pkg::cmd_wr : dram_pkg::cmd_rd;
            pre:     cmd = dram_pkg::cmd_pre;
            default: cmd = dram_pkg::cmd_act;
        endcase
    end

    // one-hot selects, held by decode for the whole request
    assign bank_sel = {{(dram_pkg::num_of_banks-1){1'b0}}, 1'b1} << req.bank_id;
    assign row_sel  = {{(dram_pkg::num_of_rows-1){1'b0}}, 1'b1} << req.row_id;
    assign col_sel  = {{(dram_pkg::num_of_cols-1){1'b0}}, 1'b1} << req.col_id;

    assign buf_en        = (state == beats);
    assign buf_rw        = req.rw;
    assign bit_idx       = access_count;          // lsb first
    assign dram_wdata    = req.wdata[access_count];
    assign rd_bit_strobe = buf_en && !req.rw;

endmodule

//--- rsp_assemble.sv
`timescale 1ns/1ps

module rsp_assemble (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            rd_bit_strobe,
    input  logic                            dram_rdata,
    output logic                            l2_rsp_strobe,
    output logic [dram_pkg::data_width-1:0] l2_rsp_data
);

    logic [$clog2(dram_pkg::data_width)-1:0] bit_cnt;
    logic [dram_pkg::data_width-1:0]         shift_reg;
    logic                                    last_bit;

    assign last_bit = (bit_cnt == dram_pkg::data_width - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt       <= '0;
            l2_rsp_strobe <= 1'b0;
        end else begin
            l2_rsp_strobe <= rd_bit_strobe && last_bit;   // one cycle after bit 7
            if (rd_bit_strobe)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // shift right, first bit ends up in bit 0
    always_ff @(posedge clk) begin
        if (rd_bit_strobe) begin
            shift_reg <= {dram_rdata, shift_reg[dram_pkg::data_width-1:1]};
            if (last_bit)
                l2_rsp_data <= {dram_rdata, shift_reg[dram_pkg::data_width-1:1]};
        end
    end

endmodule

//--- dram_ctrl.sv
`timescale 1ns/1ps

module dram_ctrl (
    input  logic                                    clk,
    input  logic                                    reset,
    // L2 side
    input  logic                                    l2_req_strobe,
    input  logic                                    l2_rw_req,
    input  logic [dram_pkg::l2_req_width-1:0]       l2_req_instr,
    input  logic [dram_pkg::data_width-1:0]         l2_req_data,
    output logic                                    l2_req_full,
    output logic                                    l2_rsp_strobe,
    output logic [dram_pkg::data_width-1:0]         l2_rsp_data,
    // DRAM side
    output logic                                    cmd_req,
    input  logic                                    cmd_ack,
    output logic [1:0]                              cmd,
    output logic [dram_pkg::num_of_banks-1:0]       bank_sel,
    output logic [dram_pkg::num_of_rows-1:0]        row_sel,
    output logic [dram_pkg::num_of_cols-1:0]        col_sel,
    output logic                                    buf_en,
    output logic                                    buf_rw,
    output logic [$clog2(dram_pkg::data_width)-1:0] bit_idx,
    output logic                                    dram_wdata,
    input  logic                                    dram_rdata
);

    logic                              buf_empty;
    logic                              buf_rd_en;
    logic                              head_rw;
    logic [dram_pkg::l2_req_width-1:0] head_instr;
    logic [dram_pkg::data_width-1:0]   head_data;
    logic                              rd_bit_strobe;

    dram_req_if req_bus ();

    l2_req_buffer l2_req_buffer_i (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (l2_req_strobe),
        .wr_rw      (l2_rw_req),
        .wr_instr   (l2_req_instr),
        .wr_data    (l2_req_data),
        .rd_en      (buf_rd_en),
        .empty      (buf_empty),
        .full       (l2_req_full),
        .head_rw    (head_rw),
        .head_instr (head_instr),
        .head_data  (head_data)
    );

    address_translate address_translate_i (
        .clk        (clk),
        .reset      (reset),
        .empty      (buf_empty),
        .head_rw    (head_rw),
        .head_instr (head_instr),
        .head_data  (head_data),
        .rd_en      (buf_rd_en),
        .req        (req_bus.decode)
    );

    dram_fsm dram_fsm_i (
        .clk           (clk),
        .reset         (reset),
        .req           (req_bus.execute),
        .cmd_ack       (cmd_ack),
        .dram_rdata    (dram_rdata),
        .cmd_req       (cmd_req),
        .cmd           (cmd),
        .bank_sel      (bank_sel),
        .row_sel       (row_sel),
        .col_sel       (col_sel),
        .buf_en        (buf_en),
        .buf_rw        (buf_rw),
        .bit_idx       (bit_idx),
        .dram_wdata    (dram_wdata),
        .rd_bit_strobe (rd_bit_strobe)
    );

    rsp_assemble rsp_assemble_i (
        .clk           (clk),
        .reset         (reset),
        .rd_bit_strobe (rd_bit_strobe),
        .dram_rdata    (dram_rdata),
        .l2_rsp_strobe (l2_rsp_strobe),
        .l2_rsp_data   (l2_rsp_data)
    );

endmodule

//--- dram_bfm.sv
`timescale 1ns/1ps

module dram_bfm (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    cmd_req,
    input  logic [1:0]                              cmd,
    input  logic [dram_pkg::num_of_banks-1:0]       bank_sel,
    input  logic [dram_pkg::num_of_rows-1:0]        row_sel,
    input  logic [dram_pkg::num_of_cols-1:0]        col_sel,
    input  logic                                    buf_en,
    input  logic                                    buf_rw,
    input  logic [$clog2(dram_pkg::data_width)-1:0] bit_idx,
    input  logic                                    dram_wdata,
    output logic                                    cmd_ack,
    output logic                                    dram_rdata
);

    localparam int row_width = dram_pkg::num_of_cols * dram_pkg::data_width;

    logic [row_width-1:0] mem [dram_pkg::num_of_banks][dram_pkg::num_of_rows];
    logic [row_width-1:0] row_buf;    // the single open row
    int cur_bank;
    int cur_row;
    int bit_pos;

    function automatic int onehot_index(input logic [127:0] sel);
        int idx;
        idx = 0;
        for (int i = 0; i < 128; i++)
            if (sel[i])
                idx = i;
        return idx;
    endfunction

    assign bit_pos    = onehot_index(128'(col_sel)) * dram_pkg::data_width + int'(bit_idx);
    assign dram_rdata = row_buf[bit_pos];   // combinational read beat

    task automatic run_command();
        case (cmd)
            dram_pkg::cmd_act: begin
                cur_bank = onehot_index(128'(bank_sel));
                cur_row  = onehot_index(128'(row_sel));
                row_buf  = mem[cur_bank][cur_row];
            end
            dram_pkg::cmd_pre: mem[cur_bank][cur_row] = row_buf;   // write back
            default: ;
        endcase
    endtask

    // everything toward the DUT moves on the falling edge
    initial begin
        int delay;
        for (int b = 0; b < dram_pkg::num_of_banks; b++)
            for (int r = 0; r < dram_pkg::num_of_rows; r++)
                mem[b][r] = '0;
        row_buf  = '0;
        cur_bank = 0;
        cur_row  = 0;
        cmd_ack  = 1'b0;
        forever begin
            @(negedge clk);
            if (reset) begin
                cmd_ack = 1'b0;
            end else if (buf_en && buf_rw) begin
                row_buf[bit_pos] = dram_wdata;
            end else if (cmd_req && !cmd_ack) begin
                delay = int'($urandom_range(4, 1));
                repeat (delay - 1) @(negedge clk);
                run_command();
                cmd_ack = 1'b1;
            end else if (!cmd_req && cmd_ack) begin
                cmd_ack = 1'b0;   // last phase of the handshake
            end
        end
    end

endmodule

//--- dram_ctrl_assert.sv
`timescale 1ns/1ps

module dram_ctrl_assert (
    input logic                                    clk,
    input logic                                    reset,
    input logic                                    cmd_req,
    input logic                                    cmd_ack,
    input logic [1:0]                              cmd,
    input logic [dram_pkg::num_of_banks-1:0]       bank_sel,
    input logic [dram_pkg::num_of_rows-1:0]        row_sel,
    input logic [dram_pkg::num_of_cols-1:0]        col_sel,
    input logic                                    buf_en,
    input logic                                    buf_rw,
    input logic [$clog2(dram_pkg::data_width)-1:0] bit_idx,
    input logic                                    l2_rsp_strobe
);

    int         fail_count = 0;
    logic       cmd_req_q;
    logic [1:0] last_cmd;   // command of the previous handshake
    logic [3:0] beat_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_req_q <= 1'b0;
            last_cmd  <= dram_pkg::cmd_pre;
            beat_cnt  <= '0;
        end else begin
            cmd_req_q <= cmd_req;
            if (cmd_req && !cmd_req_q) begin
                last_cmd <= cmd;
                if (cmd == dram_pkg::cmd_wr || cmd == dram_pkg::cmd_rd)
                    beat_cnt <= '0;
            end else if (buf_en) begin
                beat_cnt <= beat_cnt + 4'd1;
            end
        end
    end

    a_cmd_hold: assert property (@(posedge clk) disable iff (reset)
        cmd_req && !cmd_ack |=> cmd_req && $stable(cmd) && $stable(bank_sel)
                                && $stable(row_sel) && $stable(col_sel))
        else begin
            $error("command or selects changed before cmd_ack");
            fail_count++;
        end

    // ack seen in the cycle the request was raised
    a_no_rise_on_ack: assert property (@(posedge clk) disable iff (reset)
        $rose(cmd_req) |-> !$past(cmd_ack))
        else begin
            $error("cmd_req rose while cmd_ack was still high");
            fail_count++;
        end

    a_cmd_order: assert property (@(posedge clk) disable iff (reset)
        $rose(cmd_req) |->
            (cmd == dram_pkg::cmd_act && last_cmd == dram_pkg::cmd_pre)
            || ((cmd == dram_pkg::cmd_wr || cmd == dram_pkg::cmd_rd)
                && last_cmd == dram_pkg::cmd_act)
            || (cmd == dram_pkg::cmd_pre
                && (last_cmd == dram_pkg::cmd_wr || last_cmd == dram_pkg::cmd_rd)))
        else begin
            $error("command out of order");
            fail_count++;
        end

    a_eight_beats: assert property (@(posedge clk) disable iff (reset)
        $rose(cmd_req) && cmd == dram_pkg::cmd_pre |-> beat_cnt == 4'd8)
        else begin
            $error("precharge without exactly eight beats");
            fail_count++;
        end

    a_beat_step: assert property (@(posedge clk) disable iff (reset)
        buf_en && bit_idx != 3'd7 |=> buf_en && bit_idx == $past(bit_idx) + 3'd1)
        else begin
            $error("beats not back to back in bit order");
            fail_count++;
        end

    a_rsp_after_read: assert property (@(posedge clk) disable iff (reset)
        buf_en && !buf_rw && bit_idx == 3'd7 |=> l2_rsp_strobe)
        else begin
            $error("no response after the last read beat");
            fail_count++;
        end

    a_rsp_source: assert property (@(posedge clk) disable iff (reset)
        l2_rsp_strobe |-> $past(buf_en && !buf_rw && bit_idx == 3'd7))
        else begin
            $error("response without a preceding last read beat");
            fail_count++;
        end

endmodule

//--- dram_ctrl_tb.sv
`timescale 1ns/1ps

module dram_ctrl_tb;

    localparam int timeout_cycles = 2000;
    localparam int burst_len      = 14;

    logic                                    clk;
    logic                                    reset;
    logic                                    l2_req_strobe;
    logic                                    l2_rw_req;
    logic [dram_pkg::l2_req_width-1:0]       l2_req_instr;
    logic [dram_pkg::data_width-1:0]         l2_req_data;
    logic                                    l2_req_full;
    logic                                    l2_rsp_strobe;
    logic [dram_pkg::data_width-1:0]         l2_rsp_data;
    logic                                    cmd_req;
    logic                                    cmd_ack;
    logic [1:0]                              cmd;
    logic [dram_pkg::num_of_banks-1:0]       bank_sel;
    logic [dram_pkg::num_of_rows-1:0]        row_sel;
    logic [dram_pkg::num_of_cols-1:0]        col_sel;
    logic                                    buf_en;
    logic                                    buf_rw;
    logic [$clog2(dram_pkg::data_width)-1:0] bit_idx;
    logic                                    dram_wdata;
    logic                                    dram_rdata;

    // reference memory, offset is not part of the index
    logic [7:0] ref_mem [dram_pkg::num_of_banks][dram_pkg::num_of_rows][dram_pkg::num_of_cols];
    logic [7:0] exp_q [$];    // expected read bytes in issue order
    int data_errors = 0;
    int flow_errors = 0;
    int rd_count    = 0;
    int rsp_count   = 0;

    dram_ctrl dram_ctrl_i (.*);
    dram_bfm  dram_bfm_i (.*);

    bind dram_ctrl dram_ctrl_assert dram_ctrl_assert_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [19:0] pack_instr(input int bank, input int row, input int col,
                                               input int offset);
        return {4'b0, 3'(bank), 7'(row), 3'(col), 3'(offset)};
    endfunction

    task automatic send_req(input logic rw, input int bank, input int row, input int col,
                            input int offset, input logic [7:0] data);
        int waited;
        waited = 0;
        while (l2_req_full && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (l2_req_full) begin
            $display("timed out waiting for l2_req_full to clear");
            flow_errors++;
        end
        l2_req_strobe = 1'b1;
        l2_rw_req     = rw;
        l2_req_instr  = pack_instr(bank, row, col, offset);
        l2_req_data   = data;
        if (rw) begin
            ref_mem[bank][row][col] = data;
        end else begin
            exp_q.push_back(ref_mem[bank][row][col]);
            rd_count++;
        end
        @(negedge clk);
        l2_req_strobe = 1'b0;
    endtask

    task automatic check_response(input logic [7:0] got);
        logic [7:0] want;
        rsp_count++;
        if (exp_q.size() == 0) begin
            $display("got a response with data %h but no read was pending", got);
            flow_errors++;
        end else begin
            want = exp_q.pop_front();
            if (got !== want) begin
                $display("[FAIL] %0t: read data %h, expected %h", $time, got, want);
                data_errors++;
            end
        end
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timed out with %0d read responses still missing", exp_q.size());
            flow_errors++;
        end
    endtask

    // precharge of the last request still runs after its response
    task automatic wait_idle();
        int waited;
        waited = 0;
        while ((cmd_req || cmd_ack || buf_en) && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (cmd_req || cmd_ack || buf_en) begin
            $display("timed out waiting for the controller to go idle");
            flow_errors++;
        end
    endtask

    always @(negedge clk) begin
        if (!reset && l2_rsp_strobe)
            check_response(l2_rsp_data);
    end

    initial begin
        int bank_a [16];
        int row_a  [16];
        int col_a  [16];
        bit saw_full;
        int full_at;
        void'($urandom(32'h886b));
        reset         = 1'b1;
        l2_req_strobe = 1'b0;
        l2_rw_req     = 1'b0;
        l2_req_instr  = '0;
        l2_req_data   = '0;
        saw_full      = 1'b0;
        full_at       = 0;
        for (int b = 0; b < dram_pkg::num_of_banks; b++)
            for (int r = 0; r < dram_pkg::num_of_rows; r++)
                for (int c = 0; c < dram_pkg::num_of_cols; c++)
                    ref_mem[b][r][c] = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        // distinct bank and col pairs, random rows
        for (int i = 0; i < 16; i++) begin
            bank_a[i] = i % 8;
            col_a[i]  = i / 8;
            row_a[i]  = int'($urandom_range(127, 0));
            send_req(1'b1, bank_a[i], row_a[i], col_a[i], i % 8, 8'($urandom));
        end
        for (int i = 0; i < 16; i++)
            send_req(1'b0, bank_a[i], row_a[i], col_a[i], 0, 8'h00);
        wait_responses();

        // offset aliasing and a neighbour column in the same row
        send_req(1'b1, 5, 17, 3, 1, 8'ha5);
        send_req(1'b1, 5, 17, 4, 0, 8'h3c);
        send_req(1'b1, 5, 17, 3, 6, 8'h5a);
        send_req(1'b0, 5, 17, 3, 0, 8'h00);
        send_req(1'b0, 5, 17, 4, 2, 8'h00);
        wait_responses();

        // burst, acks are far slower than the strobes
        for (int i = 0; i < burst_len; i++) begin
            if (l2_req_full && !saw_full) begin
                saw_full = 1'b1;
                full_at  = i;
            end
            if (i < burst_len / 2)
                send_req(1'b1, i, 100 + i, 7 - i, 0, 8'($urandom));
            else
                send_req(1'b0, i - burst_len / 2, 100 + i - burst_len / 2,
                         7 - (i - burst_len / 2), 0, 8'h00);
        end
        if (!saw_full) begin
            $display("l2_req_full never rose during the burst");
            flow_errors++;
        end else if (full_at < dram_pkg::req_buf_depth) begin
            $display("l2_req_full rose after only %0d requests", full_at);
            flow_errors++;
        end
        wait_responses();
        wait_idle();
        if (rsp_count != rd_count) begin
            $display("%0d responses for %0d reads", rsp_count, rd_count);
            flow_errors++;
        end

        $display("data errors %0d, flow errors %0d, assertion failures %0d",
                 data_errors, flow_errors, dram_ctrl_i.dram_ctrl_assert_i.fail_count);
        if (data_errors == 0 && flow_errors == 0
            && dram_ctrl_i.dram_ctrl_assert_i.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- dram_ctrl.f
dram_pkg.sv
dram_req_if.sv
l2_req_buffer.sv
address_translate.sv
dram_fsm.sv
rsp_assemble.sv
dram_ctrl.sv
dram_bfm.sv
dram_ctrl_assert.sv
dram_ctrl_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module dram_ctrl_tb \
    -f dram_ctrl.f -o sim_dram_ctrl

if ! ./obj_dir/sim_dram_ctrl +verilator+error+limit+1000 > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "Test failures found" sim.log; then
    exit 1
fi
